// ==== src/adc_rx_pkg.sv ====
// adc receiver package with register map, widths and sequencer states
package adc_rx_pkg;

    parameter int ADC_W  = 14;  // one adc sample
    parameter int WORD_W = 32;  // one fifo word
    parameter int CNT_W  = 24;  // sample count of a run

    // byte registers on the 4-bit bus address
    typedef enum logic [3:0] {
        REG_RESET   = 4'd0,
        REG_START   = 4'd1,
        REG_CONF    = 4'd2,
        REG_CNT_HI  = 4'd3,
        REG_CNT_MID = 4'd4,
        REG_CNT_LO  = 4'd5,
        REG_LOST    = 4'd15
    } reg_addr_e;

    // bit positions inside REG_CONF
    parameter int CONF_SYNC_BIT   = 0;  // arm on sync edge
    parameter int CONF_SINGLE_BIT = 2;  // one sample per word

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_SYNC,
        SEQ_RECORD
    } seq_state_e;

endpackage

// ==== src/adc_rx_regs.sv ====
// adc receiver register bank with soft reset, start strobe, done flag and read-back
module adc_rx_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [3:0]                    bus_add,
    input  logic [7:0]                    bus_data_in,
    input  logic                          bus_wr,
    input  logic                          done_pulse,
    input  logic [7:0]                    lost_cnt,
    output logic [7:0]                    bus_data_out,
    output logic                          core_rst,
    output logic                          start,
    output logic                          start_with_sync,
    output logic                          single_mode,
    output logic [adc_rx_pkg::CNT_W-1:0]  data_cnt,
    output logic                          done
);

    logic       soft_rst_int;
    logic       wr_reset;
    logic       wr_start;
    logic [7:0] cnt_hi;
    logic [7:0] cnt_mid;
    logic [7:0] cnt_lo;
    logic [7:0] conf_byte;

    assign wr_reset = bus_wr && (adc_rx_pkg::reg_addr_e'(bus_add) == adc_rx_pkg::REG_RESET);
    assign wr_start = bus_wr && (adc_rx_pkg::reg_addr_e'(bus_add) == adc_rx_pkg::REG_START);

    // a write to register 0 resets everything behind the bus
    assign soft_rst_int = rst | wr_reset;
    assign core_rst     = soft_rst_int;

    assign data_cnt = {cnt_hi, cnt_mid, cnt_lo};

    // configuration and count bytes
    always_ff @(posedge clk) begin
        if (soft_rst_int) begin
            start_with_sync <= 1'b0;
            single_mode     <= 1'b0;
            cnt_hi          <= 8'h00;
            cnt_mid         <= 8'h00;
            cnt_lo          <= 8'h00;
        end else if (bus_wr) begin
            case (adc_rx_pkg::reg_addr_e'(bus_add))
                adc_rx_pkg::REG_CONF: begin
                    start_with_sync <= bus_data_in[adc_rx_pkg::CONF_SYNC_BIT];
                    single_mode     <= bus_data_in[adc_rx_pkg::CONF_SINGLE_BIT];
                end
                adc_rx_pkg::REG_CNT_HI:  cnt_hi  <= bus_data_in;
                adc_rx_pkg::REG_CNT_MID: cnt_mid <= bus_data_in;
                adc_rx_pkg::REG_CNT_LO:  cnt_lo  <= bus_data_in;
                default: ;
            endcase
        end
    end

    // start strobe lands one cycle after the bus write
    always_ff @(posedge clk) begin
        if (soft_rst_int) begin
            start <= 1'b0;
        end else begin
            start <= wr_start;
        end
    end

    // idle reads as done
    always_ff @(posedge clk) begin
        if (soft_rst_int) begin
            done <= 1'b1;
        end else if (start) begin
            done <= 1'b0;
        end else if (done_pulse) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        conf_byte = 8'h00;
        conf_byte[adc_rx_pkg::CONF_SYNC_BIT]   = start_with_sync;
        conf_byte[adc_rx_pkg::CONF_SINGLE_BIT] = single_mode;
    end

    // read data follows the address by one cycle
    always_ff @(posedge clk) begin
        case (adc_rx_pkg::reg_addr_e'(bus_add))
            adc_rx_pkg::REG_START:   bus_data_out <= {7'b0, done};
            adc_rx_pkg::REG_CONF:    bus_data_out <= conf_byte;
            adc_rx_pkg::REG_CNT_HI:  bus_data_out <= cnt_hi;
            adc_rx_pkg::REG_CNT_MID: bus_data_out <= cnt_mid;
            adc_rx_pkg::REG_CNT_LO:  bus_data_out <= cnt_lo;
            adc_rx_pkg::REG_LOST:    bus_data_out <= lost_cnt;
            default:                 bus_data_out <= 8'h00;  // reset reg and unused
        endcase
    end

endmodule

// ==== src/capture_sequencer.sv ====
// capture sequencer that arms on start or sync edge and times the recording window
module capture_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          start_with_sync,
    input  logic [adc_rx_pkg::CNT_W-1:0]  data_cnt,
    input  logic                          adc_sync,
    output logic                          in_window,
    output logic                          record_begin,
    output logic                          done_pulse
);

    adc_rx_pkg::seq_state_e state;

    logic                         sync_prev;
    logic                         sync_rise;
    logic                         sync_hit;
    logic                         last_sample;
    logic [adc_rx_pkg::CNT_W-1:0] sample_cnt;  // index of the current sample

    // rising edge of adc_sync
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_prev <= 1'b0;
        end else begin
            sync_prev <= adc_sync;
        end
    end

    assign sync_rise = adc_sync && !sync_prev;

    // the sync sample itself is the first of the run
    assign sync_hit  = (state == adc_rx_pkg::SEQ_WAIT_SYNC) && sync_rise;
    assign in_window = (state == adc_rx_pkg::SEQ_RECORD) || sync_hit;

    // sample_cnt is zero while waiting for sync
    assign record_begin = in_window && (sample_cnt == '0);

    // endless run when data_cnt is zero
    assign last_sample = in_window && (data_cnt != '0) && (sample_cnt >= data_cnt - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= adc_rx_pkg::SEQ_IDLE;
            sample_cnt <= '0;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= last_sample && !start;  // a restart wins over the end
            if (start) begin
                state      <= start_with_sync ? adc_rx_pkg::SEQ_WAIT_SYNC
                                              : adc_rx_pkg::SEQ_RECORD;
                sample_cnt <= '0;
            end else if (last_sample) begin
                state <= adc_rx_pkg::SEQ_IDLE;
            end else if (in_window) begin
                state <= adc_rx_pkg::SEQ_RECORD;
                // hold at the top so an endless run never shows a new begin
                if (sample_cnt != '1) begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/sample_packer.sv ====
// sample packer that forms the 32-bit fifo word from the newest and previous sample
module sample_packer #(
    parameter logic [1:0] ADC_ID    = 2'd0,
    parameter logic [0:0] HEADER_ID = 1'b0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [adc_rx_pkg::ADC_W-1:0]   adc_in,
    input  logic                           adc_sync,
    input  logic                           single_mode,
    input  logic                           record_begin,
    output logic [adc_rx_pkg::WORD_W-1:0]  word,
    output logic                           word_ready
);

    logic [adc_rx_pkg::ADC_W-1:0] prev_sample;
    logic                         pair_phase;  // high when a held sample waits

    // previous sample, taken every cycle
    always_ff @(posedge clk) begin
        prev_sample <= adc_in;
    end

    // pairing restarts on the first sample of a run
    always_ff @(posedge clk) begin
        if (rst) begin
            pair_phase <= 1'b0;
        end else if (record_begin) begin
            pair_phase <= 1'b1;
        end else begin
            pair_phase <= !pair_phase;
        end
    end

    assign word_ready = single_mode || (pair_phase && !record_begin);

    always_comb begin
        if (single_mode) begin
            word = {HEADER_ID, ADC_ID, adc_sync, {adc_rx_pkg::ADC_W{1'b0}}, adc_in};
        end else begin
            word = {HEADER_ID, ADC_ID, adc_sync, prev_sample, adc_in};
        end
    end

endmodule

// ==== src/record_fifo.sv ====
// record fifo that takes words in the window, first-word-fall-through, counts lost words
module record_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_window,
    input  logic [adc_rx_pkg::WORD_W-1:0]  word,
    input  logic                           word_ready,
    input  logic                           fifo_read,
    output logic [adc_rx_pkg::WORD_W-1:0]  fifo_data,
    output logic                           fifo_empty,
    output logic [7:0]                     lost_cnt,
    output logic                           lost_error
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [adc_rx_pkg::WORD_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]                 wr_ptr;
    logic [AW-1:0]                 rd_ptr;
    logic [AW:0]                   count;
    logic                          full;
    logic                          wr_req;
    logic                          wr_en;
    logic                          rd_en;

    assign full       = (count == (AW + 1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);

    assign wr_req = in_window && word_ready;
    assign wr_en  = wr_req && !full;  // full is judged before any pop this cycle
    assign rd_en  = fifo_read && !fifo_empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign fifo_data = mem[rd_ptr];  // head word

    // lost word counter, sticks at 255
    always_ff @(posedge clk) begin
        if (rst) begin
            lost_cnt <= 8'h00;
        end else if (wr_req && full && (lost_cnt != 8'hff)) begin
            lost_cnt <= lost_cnt + 1'b1;
        end
    end

    assign lost_error = (lost_cnt != 8'h00);

endmodule

// ==== src/adc_rx_top.sv ====
// adc receiver top level joining register bank, sequencer, packer and record fifo
module adc_rx_top #(
    parameter logic [1:0] ADC_ID     = 2'd0,
    parameter logic [0:0] HEADER_ID  = 1'b0,
    parameter int         FIFO_DEPTH = 16
) (
    input  logic                           ADC_ENC,
    input  logic                           RST,
    input  logic [adc_rx_pkg::ADC_W-1:0]   adc_in,
    input  logic                           adc_sync,
    input  logic [3:0]                     bus_add,
    input  logic [7:0]                     bus_data_in,
    input  logic                           bus_wr,
    output logic [7:0]                     bus_data_out,
    input  logic                           fifo_read,
    output logic [adc_rx_pkg::WORD_W-1:0]  fifo_data,
    output logic                           fifo_empty,
    output logic                           lost_error
);

    logic                          core_rst;
    logic                          start;
    logic                          start_with_sync;
    logic                          single_mode;
    logic [adc_rx_pkg::CNT_W-1:0]  data_cnt;
    logic                          in_window;
    logic                          record_begin;
    logic                          done_pulse;
    logic [adc_rx_pkg::WORD_W-1:0] word;
    logic                          word_ready;
    logic [7:0]                    lost_cnt;

    adc_rx_regs u_regs (
        .clk             (ADC_ENC),
        .rst             (RST),
        .bus_add         (bus_add),
        .bus_data_in     (bus_data_in),
        .bus_wr          (bus_wr),
        .done_pulse      (done_pulse),
        .lost_cnt        (lost_cnt),
        .bus_data_out    (bus_data_out),
        .core_rst        (core_rst),
        .start           (start),
        .start_with_sync (start_with_sync),
        .single_mode     (single_mode),
        .data_cnt        (data_cnt),
        .done            ()
    );

    capture_sequencer u_seq (
        .clk             (ADC_ENC),
        .rst             (core_rst),
        .start           (start),
        .start_with_sync (start_with_sync),
        .data_cnt        (data_cnt),
        .adc_sync        (adc_sync),
        .in_window       (in_window),
        .record_begin    (record_begin),
        .done_pulse      (done_pulse)
    );

    sample_packer #(
        .ADC_ID    (ADC_ID),
        .HEADER_ID (HEADER_ID)
    ) u_packer (
        .clk          (ADC_ENC),
        .rst          (core_rst),
        .adc_in       (adc_in),
        .adc_sync     (adc_sync),
        .single_mode  (single_mode),
        .record_begin (record_begin),
        .word         (word),
        .word_ready   (word_ready)
    );

    record_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (ADC_ENC),
        .rst        (core_rst),
        .in_window  (in_window),
        .word       (word),
        .word_ready (word_ready),
        .fifo_read  (fifo_read),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .lost_cnt   (lost_cnt),
        .lost_error (lost_error)
    );

endmodule

// ==== dv/adc_rx_tb.sv ====
// adc receiver testbench with directed single, double, sync, overflow and endless runs
module adc_rx_tb;

    localparam int CLK_PERIOD    = 100;
    localparam int RUN_SAMPLES   = 12 + 12 + 6 + 40 + 80;  // upper bound over all tests
    localparam int WATCHDOG_TIME = RUN_SAMPLES * 200 * CLK_PERIOD;
    localparam int MAX_POLLS     = 200;

    logic                          ADC_ENC;
    logic                          RST;
    logic [adc_rx_pkg::ADC_W-1:0]  adc_in;
    logic                          adc_sync;
    logic [3:0]                    bus_add;
    logic [7:0]                    bus_data_in;
    logic                          bus_wr;
    logic [7:0]                    bus_data_out;
    logic                          fifo_read;
    logic [adc_rx_pkg::WORD_W-1:0] fifo_data;
    logic                          fifo_empty;
    logic                          lost_error;

    adc_rx_top #(
        .ADC_ID     (2'd2),
        .HEADER_ID  (1'b1),
        .FIFO_DEPTH (16)
    ) uut (
        .ADC_ENC      (ADC_ENC),
        .RST          (RST),
        .adc_in       (adc_in),
        .adc_sync     (adc_sync),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .fifo_read    (fifo_read),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .lost_error   (lost_error)
    );

    initial begin
        ADC_ENC = 1'b0;
        forever #(CLK_PERIOD / 2) ADC_ENC = ~ADC_ENC;
    end

    always @(posedge ADC_ENC) begin
        adc_in <= adc_in + 1'b1;  // sample ramp
    end

    initial begin
        #(WATCHDOG_TIME);
        fail_now("watchdog expired before all tests finished");
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error in %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
        @(posedge ADC_ENC);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge ADC_ENC);
        bus_wr <= 1'b0;
    endtask

    // read data is registered one edge after the address
    task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
        @(posedge ADC_ENC);
        bus_add <= addr;
        @(posedge ADC_ENC);
        @(negedge ADC_ENC);
        data = bus_data_out;
    endtask

    task automatic pop_word(input string name, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge ADC_ENC);
        while (fifo_empty && waited < 4) begin
            @(negedge ADC_ENC);
            waited++;
        end
        if (fifo_empty) begin
            fail_now($sformatf("%s: FIFO ran empty while a word was still expected", name));
        end else begin
            data = fifo_data;  // head word until the pop at the next edge
            @(posedge ADC_ENC);
            fifo_read <= 1'b1;
            @(posedge ADC_ENC);
            fifo_read <= 1'b0;
        end
    endtask

    task automatic expect_empty(input string name);
        @(negedge ADC_ENC);
        check(name, 32'd1, 32'(fifo_empty));
    endtask

    task automatic wait_done(input string name);
        logic [7:0] rd;
        int         polls;
        polls = 0;
        rd    = 8'h00;
        while (rd[0] !== 1'b1) begin
            if (polls == MAX_POLLS) begin
                fail_now($sformatf("%s: done bit never came back after the run", name));
            end else begin
                bus_read(adc_rx_pkg::REG_START, rd);
                polls++;
            end
        end
    endtask

    task automatic start_run(input logic [7:0] conf, input int count,
                             output logic [13:0] first);
        bus_write(adc_rx_pkg::REG_CONF, conf);
        bus_write(adc_rx_pkg::REG_CNT_HI, count[23:16]);
        bus_write(adc_rx_pkg::REG_CNT_MID, count[15:8]);
        bus_write(adc_rx_pkg::REG_CNT_LO, count[7:0]);
        bus_write(adc_rx_pkg::REG_START, 8'h01);
        @(posedge ADC_ENC);
        @(negedge ADC_ENC);
        first = adc_in;  // first window sample when started without sync
        @(posedge ADC_ENC);
    endtask

    task automatic reset_values();
        logic [7:0] rd;
        bus_read(adc_rx_pkg::REG_START, rd);
        check("reset done bit", 32'd1, 32'(rd[0]));
        bus_read(adc_rx_pkg::REG_LOST, rd);
        check("reset lost_cnt", 32'd0, 32'(rd));
        check("reset fifo_empty", 32'd1, 32'(fifo_empty));
        check("reset lost_error", 32'd0, 32'(lost_error));
    endtask

    task automatic single_run();
        int          n;
        int          i;
        logic [31:0] w;
        logic [13:0] first;
        logic [13:0] exp_low;
        n = 1 + int'($urandom % 12);
        start_run(8'h04, n, first);
        wait_done("single_run");
        for (i = 0; i < n; i++) begin
            pop_word("single_run", w);
            exp_low = first + 14'(i);
            check($sformatf("single_run word %0d header", i), 32'h6, 32'(w[31:29]));
            check($sformatf("single_run word %0d sync", i), 32'd0, 32'(w[28]));
            check($sformatf("single_run word %0d prev", i), 32'd0, 32'(w[27:14]));
            check($sformatf("single_run word %0d low", i), 32'(exp_low), 32'(w[13:0]));
        end
        expect_empty("single_run fifo_empty");
    endtask

    task automatic double_run();
        int          n;
        int          i;
        logic [31:0] w;
        logic [13:0] first;
        logic [13:0] exp_low;
        logic [13:0] exp_prev;
        n = 2 * (1 + int'($urandom % 6));
        start_run(8'h00, n, first);
        wait_done("double_run");
        for (i = 0; i < n / 2; i++) begin
            pop_word("double_run", w);
            exp_prev = first + 14'(2 * i);  // pairs two samples apart
            exp_low  = exp_prev + 1'b1;
            check($sformatf("double_run word %0d header", i), 32'h6, 32'(w[31:29]));
            check($sformatf("double_run word %0d prev", i), 32'(exp_prev), 32'(w[27:14]));
            check($sformatf("double_run word %0d low", i), 32'(exp_low), 32'(w[13:0]));
        end
        expect_empty("double_run fifo_empty");
    endtask

    task automatic sync_run();
        int          i;
        logic [7:0]  rd;
        logic [31:0] w;
        logic [13:0] exp_low;
        start_run(8'h05, 6, exp_low);
        repeat (5) @(posedge ADC_ENC);
        bus_read(adc_rx_pkg::REG_START, rd);
        check("sync_run done before sync", 32'd0, 32'(rd[0]));
        expect_empty("sync_run no word before sync");
        @(posedge ADC_ENC);
        adc_sync <= 1'b1;
        @(negedge ADC_ENC);
        exp_low = adc_in;  // sample taken with the sync edge
        @(posedge ADC_ENC);
        adc_sync <= 1'b0;
        wait_done("sync_run");
        for (i = 0; i < 6; i++) begin
            pop_word("sync_run", w);
            check($sformatf("sync_run word %0d header", i), 32'h6, 32'(w[31:29]));
            check($sformatf("sync_run word %0d sync", i), (i == 0) ? 32'd1 : 32'd0, 32'(w[28]));
            check($sformatf("sync_run word %0d low", i), 32'(exp_low), 32'(w[13:0]));
            exp_low = exp_low + 1'b1;
        end
        expect_empty("sync_run fifo_empty");
    endtask

    task automatic overflow_run();
        int          i;
        logic [7:0]  rd;
        logic [31:0] w;
        logic [13:0] first;
        logic [13:0] exp_low;
        start_run(8'h04, 40, first);
        wait_done("overflow");
        bus_read(adc_rx_pkg::REG_LOST, rd);
        check("overflow lost_cnt", 32'd24, 32'(rd));
        check("overflow lost_error", 32'd1, 32'(lost_error));
        // leave the last word in to see the soft reset flush it
        for (i = 0; i < 15; i++) begin
            pop_word("overflow", w);
            exp_low = first + 14'(i);
            check($sformatf("overflow word %0d low", i), 32'(exp_low), 32'(w[13:0]));
        end
        @(negedge ADC_ENC);
        check("overflow sixteenth word", 32'd0, 32'(fifo_empty));
        bus_write(adc_rx_pkg::REG_RESET, 8'h00);
        bus_read(adc_rx_pkg::REG_LOST, rd);
        check("overflow lost_cnt after soft reset", 32'd0, 32'(rd));
        check("overflow lost_error after soft reset", 32'd0, 32'(lost_error));
        expect_empty("overflow fifo_empty after soft reset");
    endtask

    task automatic endless_run();
        int          i;
        logic [7:0]  rd;
        logic [31:0] w;
        logic [13:0] first;
        logic [13:0] exp_low;
        start_run(8'h04, 0, first);
        for (i = 0; i < 8; i++) begin
            pop_word("endless_run", w);
            check($sformatf("endless_run word %0d header", i), 32'h6, 32'(w[31:29]));
            if (i <= 3) begin
                exp_low = first + 14'(i);  // no word lost yet
                check($sformatf("endless_run word %0d low", i), 32'(exp_low), 32'(w[13:0]));
            end
            if (i == 3) begin
                repeat (50) @(posedge ADC_ENC);
                bus_read(adc_rx_pkg::REG_START, rd);
                check("endless_run done bit", 32'd0, 32'(rd[0]));
            end
        end
        bus_write(adc_rx_pkg::REG_RESET, 8'h00);
        for (i = 0; i < 10; i++) begin
            expect_empty($sformatf("endless_run fifo_empty after reset %0d", i));
        end
        check("endless_run lost_error after reset", 32'd0, 32'(lost_error));
    endtask

    initial begin
        void'($urandom(32'h4d99));
        RST         = 1'b1;
        adc_in      = '0;
        adc_sync    = 1'b0;
        bus_add     = 4'h0;
        bus_data_in = 8'h00;
        bus_wr      = 1'b0;
        fifo_read   = 1'b0;
        repeat (3) @(posedge ADC_ENC);
        RST <= 1'b0;
        reset_values();
        single_run();
        double_run();
        sync_run();
        overflow_run();
        endless_run();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
src/adc_rx_pkg.sv
src/adc_rx_regs.sv
src/capture_sequencer.sv
src/sample_packer.sv
src/record_fifo.sv
src/adc_rx_top.sv
dv/adc_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the adc receiver testbench with Verilator, run it and look for the pass message.
# The simulation output goes to stderr so that it stays visible while grep reads it.

cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module adc_rx_tb -f compile.f -o adc_rx_sim \
    && ./obj_dir/adc_rx_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
